// File: design/dcache_pkg.sv
/*
 * Data cache shared definitions
 * Requester opcodes, controller states and the line geometry
 * used by the cache, its controller and the bus masters
 */
package dcache_pkg;

	// Bus and cache word width
	localparam int DATA_W = 32;

	// Four words per line, selected by two offset bits
	localparam int WORDS_PER_LINE = 4;
	localparam int OFFSET_W = 2;
	localparam int LINE_W = WORDS_PER_LINE * DATA_W;

	// Requester opcodes
	typedef enum logic [1:0] {
		OP_LOAD,
		OP_STORE,
		OP_INV
	} mem_op_e;

	// Request controller states
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOOKUP,
		ST_POST,
		ST_FETCH,
		ST_FILL_DONE,
		ST_RESP
	} mu_state_e;

endpackage

// File: design/dcache_wr.sv
/*
 * Cache array write decision
 * Decodes the controller state, opcode, enable, hit and fill
 * acknowledge into registered word, line and invalidate strobes
 */
module dcache_wr
	import dcache_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,
	input  mu_state_e state,
	input  mem_op_e   op,
	input  logic      dce,
	input  logic      hit,
	input  logic      ack,
	output logic      wr_word,
	output logic      wr_line,
	output logic      clr_valid
);

	// All strobes are single-cycle pulses one clock behind the decoded state
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_word <= 1'b0;
			wr_line <= 1'b0;
			clr_valid <= 1'b0;
		end else begin
			wr_word <= 1'b0;
			wr_line <= 1'b0;
			clr_valid <= 1'b0;
			case (state)
				ST_LOOKUP: begin
					// Write-through store updates the cached copy only on a hit
					if (op == OP_STORE && dce && hit)
						wr_word <= 1'b1;
					// Invalidate drops a resident line whatever the enable
					if (op == OP_INV && hit)
						clr_valid <= 1'b1;
				end
				ST_FILL_DONE: begin
					// Line arrives from the read engine, uncached loads leave the arrays alone
					if (ack && op == OP_LOAD && dce)
						wr_line <= 1'b1;
				end
				default: ;
			endcase
		end
	end

	// The arrays take one kind of update per cycle
	a_one_write: assert property (@(posedge clk) disable iff (!arst_n)
		$onehot0({wr_word, wr_line, clr_valid}))
		else $error("dcache_wr: more than one array write strobe");

endmodule

// File: design/dcache_ram.sv
/*
 * Direct-mapped cache arrays
 * Tag, valid and data storage with a combinational tag compare,
 * single-word store update, whole-line fill and line invalidate
 */
module dcache_ram
	import dcache_pkg::*;
#(
	parameter int ADDR_W = 10,
	parameter int LINES = 16
) (
	input  logic              clk,
	input  logic              arst_n,
	input  logic [ADDR_W-1:0] addr,
	input  logic [DATA_W-1:0] wdata,
	input  logic [LINE_W-1:0] fill_data,
	input  logic              wr_word,
	input  logic              wr_line,
	input  logic              clr_valid,
	output logic              hit,
	output logic [DATA_W-1:0] rdata
);

	// Byte address splits into tag, line index, word offset and byte bits
	localparam int IDX_W = $clog2(LINES);
	localparam int TAG_W = ADDR_W - IDX_W - OFFSET_W - 2;

	logic [TAG_W-1:0]    tag_mem [LINES];
	logic [LINE_W-1:0]   data_mem [LINES];
	logic [LINES-1:0]    valid;
	logic [IDX_W-1:0]    idx;
	logic [TAG_W-1:0]    tag;
	logic [OFFSET_W-1:0] off;

	assign off = addr[OFFSET_W+1:2];
	assign idx = addr[OFFSET_W+2 +: IDX_W];
	assign tag = addr[ADDR_W-1 -: TAG_W];

	// Lookup is purely combinational on the held request address
	assign hit = valid[idx] && (tag_mem[idx] == tag);
	assign rdata = data_mem[idx][off*DATA_W +: DATA_W];

	// ============================================================
	// Valid bits
	// ============================================================
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			valid <= '0;
		else if (wr_line)
			valid[idx] <= 1'b1;
		else if (clr_valid)
			valid[idx] <= 1'b0;
	end

	// ============================================================
	// Tag and data arrays
	// ============================================================
	always_ff @(posedge clk) begin
		if (wr_line) begin
			tag_mem[idx] <= tag;
			data_mem[idx] <= fill_data;
		end else if (wr_word) begin
			// Only issued on a hit, so the tag already matches
			data_mem[idx][off*DATA_W +: DATA_W] <= wdata;
		end
	end

endmodule

// File: design/mem_unit.sv
/*
 * Request controller
 * Sequences lookup, store posting, line or word fetch and the
 * done handshake toward the requester
 */
module mem_unit
	import dcache_pkg::*;
#(
	parameter int ADDR_W = 10
) (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              req,
	input  mem_op_e           op,
	input  logic [ADDR_W-1:0] addr,
	input  logic [DATA_W-1:0] wdata,
	input  logic              dce,
	input  logic              hit,
	input  logic [DATA_W-1:0] cache_rdata,
	input  logic              wb_full,
	input  logic              rd_done,
	input  logic [LINE_W-1:0] rd_data,
	output logic              done,
	output logic [DATA_W-1:0] rdata,
	output mu_state_e         state,
	output logic              wb_push,
	output logic [ADDR_W-1:0] wb_addr,
	output logic [DATA_W-1:0] wb_data,
	output logic              rd_start,
	output logic [ADDR_W-1:0] rd_addr,
	output logic              rd_line
);

	mu_state_e           state_next;
	logic                from_fetch;
	logic [OFFSET_W-1:0] word_sel;

	// ============================================================
	// Next-state logic
	// ============================================================
	always_comb begin
		state_next = state;
		case (state)
			ST_IDLE:
				if (req)
					state_next = ST_LOOKUP;
			ST_LOOKUP: begin
				case (op)
					// Every store goes to memory, hit or not
					OP_STORE: state_next = wb_full ? ST_POST : ST_RESP;
					OP_INV:   state_next = ST_RESP;
					default:  state_next = (dce && hit) ? ST_RESP : ST_FETCH;
				endcase
			end
			// Stall here until the buffer has a free entry
			ST_POST:
				if (!wb_full)
					state_next = ST_RESP;
			// Launch cycle for the read engine
			ST_FETCH:
				state_next = ST_FILL_DONE;
			// Wait for the last word, the fill strobe is decoded off this state
			ST_FILL_DONE:
				if (rd_done)
					state_next = ST_RESP;
			ST_RESP:
				state_next = ST_IDLE;
			default:
				state_next = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_IDLE;
			done <= 1'b0;
			from_fetch <= 1'b0;
		end else begin
			state <= state_next;
			// Done coincides with the RESP cycle
			done <= (state_next == ST_RESP);
			if (state == ST_FETCH)
				from_fetch <= 1'b1;
			else if (state == ST_IDLE)
				from_fetch <= 1'b0;
		end
	end

	// Push as soon as the store sees room, in LOOKUP or later in POST
	assign wb_push = (state == ST_LOOKUP || state == ST_POST) && op == OP_STORE && !wb_full;
	assign wb_addr = addr;
	assign wb_data = wdata;

	// Cached misses fetch a whole line, uncached loads a single word
	assign rd_start = (state == ST_FETCH);
	assign rd_addr = addr;
	assign rd_line = dce;

	// The fill lands in the arrays after RESP, so a fetched load reads the line buffer
	assign word_sel = addr[OFFSET_W+1:2];
	assign rdata = from_fetch ? rd_data[word_sel*DATA_W +: DATA_W] : cache_rdata;

	a_done_in_resp: assert property (@(posedge clk) disable iff (!arst_n)
		done |-> state == ST_RESP)
		else $error("mem_unit: done outside RESP");

endmodule

// File: design/write_buffer.sv
/*
 * Posted write buffer
 * Store FIFO that drains in order as an APB write master
 */
module write_buffer
	import dcache_pkg::*;
#(
	parameter int ADDR_W = 10,
	parameter int WB_DEPTH = 4
) (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              push,
	input  logic [ADDR_W-1:0] push_addr,
	input  logic [DATA_W-1:0] push_data,
	input  logic [DATA_W-1:0] prdata,
	input  logic              pready,
	output logic              full,
	output logic              psel,
	output logic              penable,
	output logic [ADDR_W-1:0] paddr,
	output logic              pwrite,
	output logic [DATA_W-1:0] pwdata
);

	localparam int PTR_W = (WB_DEPTH > 1) ? $clog2(WB_DEPTH) : 1;
	localparam int CNT_W = $clog2(WB_DEPTH + 1);

	logic [ADDR_W-1:0] addr_q [WB_DEPTH];
	logic [DATA_W-1:0] data_q [WB_DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [CNT_W-1:0]  count;
	logic              pop;

	assign full = (count == CNT_W'(WB_DEPTH));

	// A transfer retires the head entry when the access phase completes
	assign pop = penable && pready;

	// ============================================================
	// FIFO pointers and occupancy
	// ============================================================
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(WB_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(WB_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			addr_q[wr_ptr] <= push_addr;
			data_q[wr_ptr] <= push_data;
		end
	end

	// ============================================================
	// APB write sequencer
	// ============================================================
	// Select stays up while entries remain, so drains run back to back
	assign psel = (count != '0);
	assign paddr = addr_q[rd_ptr];
	assign pwdata = data_q[rd_ptr];
	assign pwrite = 1'b1;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			penable <= 1'b0;
		else if (!penable)
			penable <= psel;
		else if (pready)
			penable <= 1'b0;
	end

	// The controller must hold a store while the buffer is full
	a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n)
		!(push && full))
		else $error("write_buffer: push while full");

endmodule

// File: design/read_engine.sv
/*
 * Fill read engine
 * APB read master that fetches one word or a whole four-word
 * line into a line buffer and pulses done at the end
 */
module read_engine
	import dcache_pkg::*;
#(
	parameter int ADDR_W = 10
) (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              start,
	input  logic [ADDR_W-1:0] start_addr,
	input  logic              line,
	input  logic [DATA_W-1:0] prdata,
	input  logic              pready,
	output logic              done,
	output logic [LINE_W-1:0] line_data,
	output logic              psel,
	output logic              penable,
	output logic [ADDR_W-1:0] paddr,
	output logic              pwrite
);

	localparam int BASE_W = ADDR_W - OFFSET_W - 2;

	logic                busy;
	logic                mode_line;
	logic [BASE_W-1:0]   base;
	logic [OFFSET_W-1:0] cnt;
	logic                last;

	// A single-word read ends after one beat, a line after the last offset
	assign last = !mode_line || (&cnt);

	assign psel = busy;
	assign pwrite = 1'b0;
	assign paddr = {base, cnt, 2'b00};

	// ============================================================
	// Beat sequencing
	// ============================================================
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			penable <= 1'b0;
			done <= 1'b0;
			mode_line <= 1'b0;
			cnt <= '0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				penable <= 1'b0;
				mode_line <= line;
				// A line always starts at word zero of its base
				cnt <= line ? '0 : start_addr[OFFSET_W+1:2];
			end else if (busy) begin
				if (!penable) begin
					penable <= 1'b1;
				end else if (pready) begin
					penable <= 1'b0;
					if (last) begin
						busy <= 1'b0;
						done <= 1'b1;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
			end
		end
	end

	// Line base and collected words
	always_ff @(posedge clk) begin
		if (start)
			base <= start_addr[ADDR_W-1:OFFSET_W+2];
		if (penable && pready)
			line_data[cnt*DATA_W +: DATA_W] <= prdata;
	end

endmodule

// File: design/apb_arbiter.sv
/*
 * Two-master APB arbiter
 * Fixed priority with the write buffer first, grant taken at
 * a setup phase and held until the access completes
 */
module apb_arbiter
	import dcache_pkg::*;
#(
	parameter int ADDR_W = 10
) (
	input  logic              clk,
	input  logic              arst_n,
	// Master 0, the write buffer
	input  logic              m0_psel,
	input  logic              m0_penable,
	input  logic [ADDR_W-1:0] m0_paddr,
	input  logic              m0_pwrite,
	input  logic [DATA_W-1:0] m0_pwdata,
	output logic [DATA_W-1:0] m0_prdata,
	output logic              m0_pready,
	// Master 1, the read engine
	input  logic              m1_psel,
	input  logic              m1_penable,
	input  logic [ADDR_W-1:0] m1_paddr,
	input  logic              m1_pwrite,
	output logic [DATA_W-1:0] m1_prdata,
	output logic              m1_pready,
	// Slave side
	output logic              s_psel,
	output logic              s_penable,
	output logic [ADDR_W-1:0] s_paddr,
	output logic              s_pwrite,
	output logic [DATA_W-1:0] s_pwdata,
	input  logic [DATA_W-1:0] s_prdata,
	input  logic              s_pready
);

	logic busy;
	logic owner;
	logic pick;
	logic gnt;

	// Write buffer wins any tie, keeping older stores ahead of fills
	assign pick = m0_psel ? 1'b0 : 1'b1;
	assign gnt = busy ? owner : pick;

	// The first granted cycle is always presented to the slave as setup
	assign s_psel = busy || m0_psel || m1_psel;
	assign s_penable = busy && (gnt ? m1_penable : m0_penable);
	assign s_paddr = gnt ? m1_paddr : m0_paddr;
	assign s_pwrite = gnt ? m1_pwrite : m0_pwrite;
	// Only master 0 writes
	assign s_pwdata = m0_pwdata;

	// A waiting master sits in access until its own pready
	assign m0_pready = s_penable && s_pready && !gnt;
	assign m1_pready = s_penable && s_pready && gnt;
	assign m0_prdata = s_prdata;
	assign m1_prdata = s_prdata;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			owner <= 1'b0;
		end else if (!busy) begin
			if (m0_psel || m1_psel) begin
				busy <= 1'b1;
				owner <= pick;
			end
		end else if (s_penable && s_pready) begin
			busy <= 1'b0;
		end
	end

	a_grant_held: assert property (@(posedge clk) disable iff (!arst_n)
		(s_penable && !s_pready) |=> (busy && $stable(owner)))
		else $error("apb_arbiter: grant moved during a pending access");

endmodule

// File: design/apb_mem.sv
/*
 * APB word memory
 * Zero-wait-state slave, cleared at reset, written in the
 * access phase and read combinationally
 */
module apb_mem
	import dcache_pkg::*;
#(
	parameter int ADDR_W = 10
) (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              psel,
	input  logic              penable,
	input  logic [ADDR_W-1:0] paddr,
	input  logic              pwrite,
	input  logic [DATA_W-1:0] pwdata,
	output logic [DATA_W-1:0] prdata,
	output logic              pready
);

	localparam int WORDS = 2 ** (ADDR_W - 2);

	logic [DATA_W-1:0] mem [WORDS];

	// Every transfer completes in its first access cycle
	assign pready = 1'b1;
	assign prdata = mem[paddr[ADDR_W-1:2]];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < WORDS; i++)
				mem[i] <= '0;
		end else if (psel && penable && pwrite) begin
			mem[paddr[ADDR_W-1:2]] <= pwdata;
		end
	end

endmodule

// File: design/dcache_top.sv
/*
 * Write-through data cache subsystem
 * Controller, cache arrays, posted write buffer and fill reader
 * sharing one APB bus to a backing word memory
 */
module dcache_top
	import dcache_pkg::*;
#(
	parameter int ADDR_W = 10,
	parameter int LINES = 16,
	parameter int WB_DEPTH = 4
) (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              req,
	input  mem_op_e           op,
	input  logic [ADDR_W-1:0] addr,
	input  logic [DATA_W-1:0] wdata,
	input  logic              dce,
	output logic              done,
	output logic [DATA_W-1:0] rdata
);

	// Controller and cache
	mu_state_e         state;
	logic              hit;
	logic [DATA_W-1:0] cache_rdata;
	logic              wr_word;
	logic              wr_line;
	logic              clr_valid;

	// Controller to bus masters
	logic              wb_push;
	logic [ADDR_W-1:0] wb_addr;
	logic [DATA_W-1:0] wb_data;
	logic              wb_full;
	logic              rd_start;
	logic [ADDR_W-1:0] rd_addr;
	logic              rd_line;
	logic              rd_done;
	logic [LINE_W-1:0] rd_data;

	// APB, master 0 is the write buffer and master 1 the read engine
	logic              m0_psel, m0_penable, m0_pwrite, m0_pready;
	logic [ADDR_W-1:0] m0_paddr;
	logic [DATA_W-1:0] m0_pwdata, m0_prdata;
	logic              m1_psel, m1_penable, m1_pwrite, m1_pready;
	logic [ADDR_W-1:0] m1_paddr;
	logic [DATA_W-1:0] m1_prdata;
	logic              s_psel, s_penable, s_pwrite, s_pready;
	logic [ADDR_W-1:0] s_paddr;
	logic [DATA_W-1:0] s_pwdata, s_prdata;

	// ============================================================
	// Request path
	// ============================================================
	// Array writes land at the end of the done cycle, while the request is still held
	mem_unit #(.ADDR_W(ADDR_W)) u_mem_unit (
		.clk(clk), .arst_n(arst_n), .req(req), .op(op), .addr(addr),
		.wdata(wdata), .dce(dce), .hit(hit), .cache_rdata(cache_rdata),
		.wb_full(wb_full), .rd_done(rd_done), .rd_data(rd_data),
		.done(done), .rdata(rdata), .state(state), .wb_push(wb_push),
		.wb_addr(wb_addr), .wb_data(wb_data), .rd_start(rd_start),
		.rd_addr(rd_addr), .rd_line(rd_line)
	);

	dcache_wr u_dcache_wr (
		.clk(clk), .arst_n(arst_n), .state(state), .op(op), .dce(dce),
		.hit(hit), .ack(rd_done), .wr_word(wr_word), .wr_line(wr_line),
		.clr_valid(clr_valid)
	);

	dcache_ram #(.ADDR_W(ADDR_W), .LINES(LINES)) u_dcache_ram (
		.clk(clk), .arst_n(arst_n), .addr(addr), .wdata(wdata),
		.fill_data(rd_data), .wr_word(wr_word), .wr_line(wr_line),
		.clr_valid(clr_valid), .hit(hit), .rdata(cache_rdata)
	);

	// ============================================================
	// Memory bus
	// ============================================================
	write_buffer #(.ADDR_W(ADDR_W), .WB_DEPTH(WB_DEPTH)) u_write_buffer (
		.clk(clk), .arst_n(arst_n), .push(wb_push), .push_addr(wb_addr),
		.push_data(wb_data), .prdata(m0_prdata), .pready(m0_pready),
		.full(wb_full), .psel(m0_psel), .penable(m0_penable),
		.paddr(m0_paddr), .pwrite(m0_pwrite), .pwdata(m0_pwdata)
	);

	read_engine #(.ADDR_W(ADDR_W)) u_read_engine (
		.clk(clk), .arst_n(arst_n), .start(rd_start), .start_addr(rd_addr),
		.line(rd_line), .prdata(m1_prdata), .pready(m1_pready),
		.done(rd_done), .line_data(rd_data), .psel(m1_psel),
		.penable(m1_penable), .paddr(m1_paddr), .pwrite(m1_pwrite)
	);

	apb_arbiter #(.ADDR_W(ADDR_W)) u_apb_arbiter (
		.clk(clk), .arst_n(arst_n),
		.m0_psel(m0_psel), .m0_penable(m0_penable), .m0_paddr(m0_paddr),
		.m0_pwrite(m0_pwrite), .m0_pwdata(m0_pwdata), .m0_prdata(m0_prdata),
		.m0_pready(m0_pready),
		.m1_psel(m1_psel), .m1_penable(m1_penable), .m1_paddr(m1_paddr),
		.m1_pwrite(m1_pwrite), .m1_prdata(m1_prdata), .m1_pready(m1_pready),
		.s_psel(s_psel), .s_penable(s_penable), .s_paddr(s_paddr),
		.s_pwrite(s_pwrite), .s_pwdata(s_pwdata), .s_prdata(s_prdata),
		.s_pready(s_pready)
	);

	apb_mem #(.ADDR_W(ADDR_W)) u_apb_mem (
		.clk(clk), .arst_n(arst_n), .psel(s_psel), .penable(s_penable),
		.paddr(s_paddr), .pwrite(s_pwrite), .pwdata(s_pwdata),
		.prdata(s_prdata), .pready(s_pready)
	);

endmodule

// File: verif/dcache_tb.sv
/*
 * Data cache subsystem testbench
 * Directed and LFSR-driven loads, stores and invalidates checked
 * against a reference model of the backing memory and the cache lines
 */
module dcache_tb
	import dcache_pkg::*;
;
	timeunit 1ns;
	timeprecision 1ns;

	// Geometry of the cache under test
	localparam int ADDR_W = 10;
	localparam int LINES = 16;
	localparam int WB_DEPTH = 4;
	localparam int WORD_W = ADDR_W - 2;
	localparam int IDX_W = $clog2(LINES);
	localparam int TAG_W = ADDR_W - IDX_W - 4;

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 4;
	localparam int NUM_RANDOM = 200;
	// About 16 cycles per request over at most 250 requests in the whole run
	localparam int MAX_CYCLES = 4000;
	localparam logic [31:0] LFSR_SEED = 32'he65d;
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

	logic              clk;
	logic              arst_n;
	logic              req;
	mem_op_e           op;
	logic [ADDR_W-1:0] addr;
	logic [31:0]       wdata;
	logic              dce;
	logic              done;
	logic [31:0]       rdata;

	logic [31:0]      lfsr;
	int               cycle_count;

	// Reference model of memory and of the cache contents
	logic [31:0]      mem_model [2**WORD_W];
	logic             cache_valid [LINES];
	logic [TAG_W-1:0] cache_tag [LINES];
	logic [31:0]      cache_data [LINES][4];

	dcache_top #(.ADDR_W(ADDR_W), .LINES(LINES), .WB_DEPTH(WB_DEPTH)) dut (
		.clk(clk), .arst_n(arst_n), .req(req), .op(op), .addr(addr),
		.wdata(wdata), .dce(dce), .done(done), .rdata(rdata)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ============================================================
	// Random numbers and address fields
	// ============================================================
	// Galois LFSR, one step for every bit handed out
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			val = {val[30:0], lfsr[0]};
			lfsr = (lfsr >> 1) ^ (lfsr[0] ? LFSR_TAPS : 32'h0);
		end
		return val;
	endfunction

	function automatic logic [IDX_W-1:0] line_of(input logic [ADDR_W-1:0] a);
		return a[4 +: IDX_W];
	endfunction

	function automatic logic [TAG_W-1:0] tag_of(input logic [ADDR_W-1:0] a);
		return a[ADDR_W-1 -: TAG_W];
	endfunction

	function automatic logic model_hit(input logic [ADDR_W-1:0] a);
		return cache_valid[line_of(a)] && (cache_tag[line_of(a)] == tag_of(a));
	endfunction

	// ============================================================
	// Request driver and checks
	// ============================================================
	task automatic check_word(input string test, input logic [ADDR_W-1:0] a,
			input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else begin
			$display("Error: %s addr %h expected %h actual %h", test, a, exp, act);
			$display("SOME TESTS FAILED");
			$fatal(1, "load data mismatch");
		end
	endtask

	// Called on a falling edge, returns on the falling edge after done
	task automatic issue(input mem_op_e o, input logic [ADDR_W-1:0] a,
			input logic [31:0] d, input logic e, output logic [31:0] got);
		req = 1'b1;
		op = o;
		addr = a;
		wdata = d;
		dce = e;
		do
			@(negedge clk);
		while (!done);
		got = rdata;
		// The request stays up through the done cycle so array writes see it
		@(negedge clk);
		req = 1'b0;
		assert (!done) else begin
			$display("done stayed high for more than one cycle");
			$display("SOME TESTS FAILED");
			$fatal(1, "done not a pulse");
		end
	endtask

	task automatic load(input string test, input logic [ADDR_W-1:0] a, input logic e);
		logic [31:0] exp;
		logic [31:0] got;
		if (e && model_hit(a))
			exp = cache_data[line_of(a)][a[3:2]];
		else
			exp = mem_model[a[ADDR_W-1:2]];
		issue(OP_LOAD, a, 32'h0, e, got);
		check_word(test, a, exp, got);
		// A cached miss brings the whole line in from memory
		if (e && !model_hit(a)) begin
			cache_valid[line_of(a)] = 1'b1;
			cache_tag[line_of(a)] = tag_of(a);
			for (int w = 0; w < 4; w++)
				cache_data[line_of(a)][w] = mem_model[{a[ADDR_W-1:4], 2'(w)}];
		end
	endtask

	task automatic store(input logic [ADDR_W-1:0] a, input logic [31:0] d, input logic e);
		logic [31:0] got;
		issue(OP_STORE, a, d, e, got);
		mem_model[a[ADDR_W-1:2]] = d;
		if (e && model_hit(a))
			cache_data[line_of(a)][a[3:2]] = d;
	endtask

	task automatic invalidate(input logic [ADDR_W-1:0] a, input logic e);
		logic [31:0] got;
		issue(OP_INV, a, 32'h0, e, got);
		if (model_hit(a))
			cache_valid[line_of(a)] = 1'b0;
	endtask

	// ============================================================
	// Directed tests
	// ============================================================
	task automatic test_store_load();
		logic [ADDR_W-1:0] lines [4];
		lines = '{10'h040, 10'h084, 10'h108, 10'h1cc};
		foreach (lines[i])
			store(lines[i], rand_bits(32), 1'b1);
		// First pass misses and fills, second pass hits
		foreach (lines[i])
			load("test_store_load", lines[i], 1'b1);
		foreach (lines[i])
			load("test_store_load", lines[i], 1'b1);
	endtask

	task automatic test_store_hit();
		store(10'h044, rand_bits(32), 1'b1);
		load("test_store_hit", 10'h044, 1'b1);
		load("test_store_hit", 10'h040, 1'b1);
	endtask

	task automatic test_uncached();
		// Memory changes behind the cached copy of this line
		store(10'h084, rand_bits(32), 1'b0);
		load("test_uncached", 10'h084, 1'b1);
		load("test_uncached", 10'h084, 1'b0);
	endtask

	task automatic test_invalidate();
		invalidate(10'h084, 1'b1);
		load("test_invalidate", 10'h084, 1'b1);
	endtask

	task automatic test_backpressure();
		logic [ADDR_W-1:0] seq [6];
		seq = '{10'h200, 10'h204, 10'h208, 10'h200, 10'h20c, 10'h200};
		foreach (seq[i])
			store(seq[i], rand_bits(32), 1'b0);
		// Newest store to 0x200 has to reach memory before the read
		load("test_backpressure", 10'h200, 1'b0);
		load("test_backpressure", 10'h208, 1'b0);
	endtask

	task automatic test_random();
		logic [31:0]       r;
		logic [ADDR_W-1:0] a;
		logic              e;
		for (int i = 0; i < NUM_RANDOM; i++) begin
			r = rand_bits(2);
			// Word index from the LFSR, byte bits stay zero
			a = ADDR_W'(rand_bits(WORD_W) << 2);
			e = 1'(rand_bits(1));
			case (r[1:0])
				2'd2:    store(a, rand_bits(32), e);
				2'd3:    invalidate(a, e);
				default: load("test_random", a, e);
			endcase
		end
	endtask

	// ============================================================
	// Main sequence and watchdog
	// ============================================================
	initial begin
		arst_n = 1'b0;
		req = 1'b0;
		op = OP_LOAD;
		addr = '0;
		wdata = '0;
		dce = 1'b0;
		lfsr = LFSR_SEED;
		// Memory comes out of reset cleared and the cache empty
		foreach (mem_model[i])
			mem_model[i] = '0;
		foreach (cache_valid[i])
			cache_valid[i] = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk);
		arst_n = 1'b1;
		test_store_load();
		test_store_hit();
		test_uncached();
		test_invalidate();
		test_backpressure();
		test_random();
		$display("ALL TESTS PASSED");
		$finish;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < MAX_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout after %0d cycles, a request never completed", MAX_CYCLES);
		$display("SOME TESTS FAILED");
		$fatal(1, "simulation timeout");
	end

endmodule

// File: flist.f
design/dcache_pkg.sv
design/dcache_wr.sv
design/dcache_ram.sv
design/mem_unit.sv
design/write_buffer.sv
design/read_engine.sv
design/apb_arbiter.sv
design/apb_mem.sv
design/dcache_top.sv
verif/dcache_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= dcache_tb
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
SIM_BIN ?= sim
VFLAGS ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

# A $fatal in the testbench gives a nonzero exit status
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) \
		-Mdir $(BUILD_DIR) -o $(SIM_BIN)
	./$(BUILD_DIR)/$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
